// File: verilog/sched_pkg.sv
`default_nettype none

package sched_pkg;

	localparam int num_cores = 4;
	localparam int task_depth = 16;
	localparam int frame_bits = 128;
	localparam int beats_per_frame = 4;     // 32-bit beats per instruction frame
	localparam int r0_width = 16;

	typedef logic [$clog2(task_depth)-1:0] task_addr_t;
	typedef logic [num_cores-1:0] core_vect_t;
	typedef logic [$clog2(beats_per_frame)-1:0] beat_t;
	typedef logic [3:0] frame_cnt_t;

	// acq holds the next control frame, rel holds this one
	typedef enum logic [1:0] {
		fence_no  = 2'd0,
		fence_acq = 2'd1,
		fence_rel = 2'd2
	} fence_t;

	localparam int ctrl_bits = $bits(frame_cnt_t) + $bits(fence_t) + 1 + $bits(task_addr_t)
		+ 2 * num_cores + num_cores * r0_width;
	localparam int reserved_bits = frame_bits - ctrl_bits;

	// Control frame view, insn_frames sits in the low nibble
	typedef struct packed {
		logic [reserved_bits-1:0] reserved;
		logic [num_cores-1:0][r0_width-1:0] init_r0;
		core_vect_t init_vect;
		core_vect_t active;
		task_addr_t stop_addr;
		logic stop;
		fence_t fence;
		frame_cnt_t insn_frames;
	} task_frame_t;

	typedef task_frame_t [task_depth-1:0] task_image_t;     // Frame 0 in the low bits

endpackage

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

	localparam int imm_width = 12;
	localparam int frame_insns = 2 * sched_pkg::beats_per_frame;

	typedef logic [sched_pkg::r0_width-1:0] reg_t;
	typedef reg_t [sched_pkg::num_cores-1:0] r0_bus_t;
	typedef logic [$clog2(frame_insns)-1:0] pc_t;

	typedef enum logic [3:0] {
		op_nop = 4'd0,
		op_add = 4'd1,
		op_xor = 4'd2,
		op_shl = 4'd3,
		op_sub = 4'd4
	} opcode_t;

	typedef struct packed {
		opcode_t op;
		logic [imm_width-1:0] imm;
	} insn_t;

	// Index 0 runs first
	typedef insn_t [1:0] insn_pair_t;

endpackage

`default_nettype wire

// File: verilog/frame_core.sv
`default_nettype none

module frame_core (
	input wire clk,
	input wire reset,
	input wire start,
	input wire init,
	input wire core_pkg::reg_t init_value,
	input wire sched_pkg::beat_t load_count,
	input wire core_pkg::insn_pair_t insn_data,
	output logic ready,
	output core_pkg::reg_t r0
);

	import sched_pkg::*;
	import core_pkg::*;

	logic running;
	logic init_d;
	logic init_edge;
	pc_t pc;
	insn_pair_t ibuf [beats_per_frame];
	insn_t cur;

	function automatic reg_t alu(input insn_t insn, input reg_t value);
		reg_t imm_ext;
		imm_ext = reg_t'(insn.imm);
		case (insn.op)
			op_add: return value + imm_ext;
			op_sub: return value - imm_ext;
			op_xor: return value ^ imm_ext;
			op_shl: return value << insn.imm[3:0];
			default: return value;
		endcase
	endfunction

	assign init_edge = init && !init_d;
	assign ready = !running && !init_edge;    // Pending init counts as busy
	assign cur = ibuf[pc[$bits(pc_t)-1:1]][pc[0]];

	// Beats only land while the core sits idle
	always_ff @(posedge clk) begin
		if (!running && !start) begin
			ibuf[load_count] <= insn_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			running <= 1'b0;
			pc <= '0;
			init_d <= 1'b0;
		end else begin
			init_d <= init;
			if (start) begin
				running <= 1'b1;
				pc <= '0;
			end else if (running) begin
				pc <= pc + 1'b1;
				if (pc == pc_t'(frame_insns - 1)) begin
					running <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
		end else if (init_edge) begin
			r0 <= init_value;
		end else if (running) begin
			r0 <= alu(cur, r0);
		end
	end

	a_start_idle: assert property (
		@(posedge clk) disable iff (reset)
		start |-> !running
	) else $error("start while core busy");

endmodule

`default_nettype wire

// File: verilog/task_scheduler.sv
`default_nettype none

module task_scheduler #(
	parameter int load_time = 4
) (
	input wire clk,
	input wire reset,
	input wire sched_pkg::task_image_t task_image,
	input wire sched_pkg::core_vect_t ready,
	input wire blanking,
	output sched_pkg::core_vect_t start,
	output sched_pkg::beat_t load_count,
	output core_pkg::insn_pair_t insn_data,
	output sched_pkg::core_vect_t init_vect,
	output core_pkg::r0_bus_t init_r0,
	output logic snap_req,
	output logic idle
);

	import sched_pkg::*;
	import core_pkg::*;

	localparam int cnt_w = (load_time > 1) ? $clog2(load_time) : 1;

	typedef enum logic [1:0] {
		st_ctrl,
		st_load,
		st_start,
		st_run
	} state_t;

	state_t state;
	task_addr_t ptr;
	frame_cnt_t frames_left;
	core_vect_t active_r;
	fence_t fence_r;
	logic stop_r;
	task_addr_t stop_addr_r;
	logic [cnt_w-1:0] lcnt;
	logic snap_done;

	task_frame_t frame;
	insn_pair_t [beats_per_frame-1:0] beats;
	logic fence_wait;
	logic ctrl_go;
	logic group_done;
	logic halt_here;

	assign frame = task_image[ptr];
	assign beats = frame;                   // Same bits seen as instruction beats

	assign load_count = beat_t'(lcnt);
	assign insn_data = beats[load_count];

	// Previous acq or own rel means the whole array must be idle
	assign fence_wait = (fence_r == fence_acq) || (frame.fence == fence_rel);

	assign ctrl_go = blanking && (state == st_ctrl)
		&& ((ready & frame.active) == frame.active)
		&& (!fence_wait || (&ready));

	assign group_done = (ready & active_r) == active_r;

	assign halt_here = (frame.insn_frames == '0) && frame.stop && (frame.stop_addr == ptr);

	assign start = (state == st_start && blanking) ? active_r : '0;

	// Once per display period, after the array settles
	assign snap_req = !blanking && !snap_done && (&ready);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_ctrl;
			ptr <= '0;
			frames_left <= '0;
			active_r <= '0;
			fence_r <= fence_no;
			stop_r <= 1'b0;
			lcnt <= '0;
			init_vect <= '0;
		end else if (blanking) begin
			case (state)
				st_ctrl: begin
					if (ctrl_go) begin
						fence_r <= frame.fence;
						active_r <= frame.active;
						stop_r <= frame.stop;
						init_vect <= frame.init_vect;
						frames_left <= frame.insn_frames;
						if (frame.insn_frames != '0) begin
							ptr <= ptr + 1'b1;
							state <= st_load;
						end else if (frame.stop) begin
							ptr <= frame.stop_addr;     // Halt frame points at itself
						end else begin
							ptr <= ptr + 1'b1;
						end
					end
				end
				st_load: begin
					if (int'(lcnt) == load_time - 1) begin
						lcnt <= '0;
						state <= st_start;
					end else begin
						lcnt <= lcnt + 1'b1;
					end
				end
				st_start: begin
					state <= st_run;
				end
				st_run: begin
					if (group_done) begin
						frames_left <= frames_left - 1'b1;
						if (frames_left == frame_cnt_t'(1)) begin
							state <= st_ctrl;
							ptr <= stop_r ? stop_addr_r : ptr + 1'b1;
						end else begin
							state <= st_load;
							ptr <= ptr + 1'b1;
						end
					end
				end
				default: begin
					state <= st_ctrl;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_go) begin
			stop_addr_r <= frame.stop_addr;
			init_r0 <= frame.init_r0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			snap_done <= 1'b0;
		end else if (blanking) begin
			snap_done <= 1'b0;
		end else if (snap_req) begin
			snap_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idle <= 1'b0;
		end else begin
			idle <= (state == st_ctrl) && halt_here && (&ready);
		end
	end

	// A core must be idle when its start arrives
	a_start_ready: assert property (
		@(posedge clk) disable iff (reset)
		(start & ~ready) == '0
	) else $error("start sent to a busy core");

	a_load_range: assert property (
		@(posedge clk) disable iff (reset)
		int'(lcnt) < load_time
	) else $error("load counter out of range");

endmodule

`default_nettype wire

// File: verilog/display_timer.sv
`default_nettype none

module display_timer #(
	parameter int display_cycles = 32,
	parameter int blank_cycles = 64
) (
	input wire clk,
	input wire reset,
	input wire snap_req,
	input wire core_pkg::r0_bus_t core_r0,
	output logic blanking,
	output core_pkg::r0_bus_t frame_r0,
	output logic frame_strobe
);

	localparam int period = display_cycles + blank_cycles;
	localparam int cnt_w = $clog2(period);

	logic [cnt_w-1:0] period_cnt;

	// Blanking first, then display
	always_ff @(posedge clk) begin
		if (reset) begin
			period_cnt <= '0;
		end else if (period_cnt == cnt_w'(period - 1)) begin
			period_cnt <= '0;
		end else begin
			period_cnt <= period_cnt + 1'b1;
		end
	end

	assign blanking = period_cnt < cnt_w'(blank_cycles);

	always_ff @(posedge clk) begin
		if (snap_req) begin
			frame_r0 <= core_r0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frame_strobe <= 1'b0;
		end else begin
			frame_strobe <= snap_req;     // Snapshot valid from here
		end
	end

endmodule

`default_nettype wire

// File: verilog/many_core_top.sv
`default_nettype none

module many_core_top #(
	parameter int load_time = 4,
	parameter int display_cycles = 32,
	parameter int blank_cycles = 64
) (
	input wire clk,
	input wire reset,
	input wire sched_pkg::task_image_t task_image,
	output wire core_pkg::r0_bus_t core_r0,
	output wire sched_pkg::core_vect_t busy,
	output wire display_active,
	output wire core_pkg::r0_bus_t frame_r0,
	output wire frame_strobe,
	output wire idle
);

	import sched_pkg::*;
	import core_pkg::*;

	wire core_vect_t start;
	wire core_vect_t ready;
	wire core_vect_t init_vect;
	wire r0_bus_t init_r0;
	wire beat_t load_count;
	wire insn_pair_t insn_data;
	wire blanking;
	wire snap_req;

	assign busy = ~ready;
	// Shown once the array is settled and captured
	assign display_active = !blanking && (&ready) && !snap_req;

	task_scheduler #(
		.load_time(load_time)
	) u_sched (
		.clk(clk),
		.reset(reset),
		.task_image(task_image),
		.ready(ready),
		.blanking(blanking),
		.start(start),
		.load_count(load_count),
		.insn_data(insn_data),
		.init_vect(init_vect),
		.init_r0(init_r0),
		.snap_req(snap_req),
		.idle(idle)
	);

	for (genvar i = 0; i < num_cores; i++) begin : g_core
		frame_core u_core (
			.clk(clk),
			.reset(reset),
			.start(start[i]),
			.init(init_vect[i]),
			.init_value(init_r0[i]),
			.load_count(load_count),
			.insn_data(insn_data),
			.ready(ready[i]),
			.r0(core_r0[i])
		);
	end

	display_timer #(
		.display_cycles(display_cycles),
		.blank_cycles(blank_cycles)
	) u_display (
		.clk(clk),
		.reset(reset),
		.snap_req(snap_req),
		.core_r0(core_r0),
		.blanking(blanking),
		.frame_r0(frame_r0),
		.frame_strobe(frame_strobe)
	);

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk
);

	initial clk = 1'b0;

	always #4 clk = ~clk;     // Period 8

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
`default_nettype none

module tb_checker (
	input wire clk,
	input wire reset,
	input wire core_pkg::r0_bus_t core_r0,
	input wire sched_pkg::core_vect_t busy,
	input wire display_active,
	input wire core_pkg::r0_bus_t frame_r0,
	input wire frame_strobe,
	input wire idle,
	input wire core_pkg::r0_bus_t expected_r0,
	input wire check_final,
	output int error_count
);

	import sched_pkg::*;
	import core_pkg::*;

	int errors = 0;
	r0_bus_t prev_r0 = '0;
	logic prev_display = 1'b0;
	logic prev_reset = 1'b1;

	assign error_count = errors;

	// Sampled at negedge, half a cycle away from the DUT edge
	always @(negedge clk) begin
		if (reset || prev_reset) begin
			if (busy !== '0 || idle !== 1'b0 || frame_strobe !== 1'b0) begin
				$display("MISMATCH reset_state expected busy=0 idle=0 strobe=0 actual %b %b %b",
					busy, idle, frame_strobe);
				errors++;
			end
		end else begin
			if (display_active && prev_display && core_r0 !== prev_r0) begin
				$display("MISMATCH display_freeze expected %h actual %h", prev_r0, core_r0);
				errors++;
			end
			if (frame_strobe && frame_r0 !== prev_r0) begin     // Value from the snap_req cycle
				$display("MISMATCH snapshot expected %h actual %h", prev_r0, frame_r0);
				errors++;
			end
		end
		if (check_final) begin
			for (int i = 0; i < num_cores; i++) begin
				if (core_r0[i] !== expected_r0[i]) begin
					$display("MISMATCH final_r0[%0d] expected %h actual %h",
						i, expected_r0[i], core_r0[i]);
					errors++;
				end
			end
		end
		prev_r0 = core_r0;
		prev_display = display_active;
		prev_reset = reset;
	end

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`default_nettype none

module tb_top;

	import sched_pkg::*;
	import core_pkg::*;

	localparam int image_words = task_depth + num_cores;

	wire clk;
	logic reset;
	task_image_t task_image;
	wire r0_bus_t core_r0;
	wire core_vect_t busy;
	wire display_active;
	wire r0_bus_t frame_r0;
	wire frame_strobe;
	wire idle;
	logic [frame_bits-1:0] stim_mem [image_words];
	r0_bus_t expected_r0;
	logic check_final;
	int error_count;
	int timeout_count;
	logic ok;

	tb_clock u_clock (
		.clk(clk)
	);

	many_core_top dut (
		.clk(clk),
		.reset(reset),
		.task_image(task_image),
		.core_r0(core_r0),
		.busy(busy),
		.display_active(display_active),
		.frame_r0(frame_r0),
		.frame_strobe(frame_strobe),
		.idle(idle)
	);

	tb_checker u_checker (
		.clk(clk),
		.reset(reset),
		.core_r0(core_r0),
		.busy(busy),
		.display_active(display_active),
		.frame_r0(frame_r0),
		.frame_strobe(frame_strobe),
		.idle(idle),
		.expected_r0(expected_r0),
		.check_final(check_final),
		.error_count(error_count)
	);

	// sel 0 waits for idle, sel 1 for frame_strobe
	task automatic wait_for_level(input int sel, input int limit, input string what,
		output logic found);
		int cycles;
		found = 1'b0;
		cycles = 0;
		while (!found && cycles < limit) begin
			@(posedge clk);
			#1;
			found = (sel == 0) ? idle : frame_strobe;
			cycles++;
		end
		if (!found) begin
			$display("Timeout: %s did not arrive within %0d cycles", what, limit);
			timeout_count++;
		end
	endtask

	task automatic report_and_finish();
		$display("Errors: mismatches=%0d timeouts=%0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin
		reset = 1'b1;
		check_final = 1'b0;
		timeout_count = 0;
		task_image = '0;
		expected_r0 = '0;
		$readmemh("dv/program_stimulus.txt", stim_mem);
		for (int i = 0; i < task_depth; i++) begin
			task_image[i] = task_frame_t'(stim_mem[i]);
		end
		for (int i = 0; i < num_cores; i++) begin
			expected_r0[i] = reg_t'(stim_mem[task_depth + i]);     // Trailing words
		end
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
		wait_for_level(0, 4000, "idle", ok);
		if (ok) begin
			check_final = 1'b1;
			@(posedge clk);
			#1;
			check_final = 1'b0;
			wait_for_level(1, 400, "first frame_strobe", ok);
		end
		if (ok) begin
			wait_for_level(1, 400, "second frame_strobe", ok);
		end
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: dv/program_stimulus.txt
// Words 0-15: task frames, 128-bit hex each, shorter words are zero-extended
// Words 16-19: expected final r0 of cores 0 to 3
800000000829801 // ctrl: 1 frame, cores 0,1 active, init core 0 and core 2
30012800000011234003300220ff1005
6021 // ctrl: 1 frame, cores 2,3 active, fence_rel
1001200f410030031fff20f030044001
55e000017bd1 // ctrl: 1 frame, all active, fence_acq, re-init core 1, stop to 7
00002a00100a30014020000025551010
11111111111111111111111111111111 // skipped frame
3bbb8000000024802 // ctrl: 2 frames, cores 0,3 active, re-init core 2
000000000000000040502fff13213004
0000000000000000000010ab30024001
540 // halt
0
0
0
0
0
c5df
14fc
7777
91df

// File: sources.f
verilog/sched_pkg.sv
verilog/core_pkg.sv
verilog/frame_core.sv
verilog/task_scheduler.sv
verilog/display_timer.sv
verilog/many_core_top.sv
dv/tb_clock.sv
dv/tb_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f sources.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
exit 0
